// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
TOP        ?= fifo4_tb
RTL_TOP    ?= fifo4_top
FILELIST   ?= fifo4.f
RTL_FILES  := fifo4_pkg.sv fifo4_ctrl.sv fifo4_ptr_unit.sv fifo4_mem.sv fifo4_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf obj_dir

// ==== fifo4.f ====
fifo4_pkg.sv
fifo4_ctrl.sv
fifo4_ptr_unit.sv
fifo4_mem.sv
fifo4_top.sv
fifo4_props.sv
fifo4_tb.sv

// ==== fifo4_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_ctrl import fifo4_pkg::*; (
   input  logic clk,
   input  logic rst,
   input  logic add_fifo,
   input  logic pop_fifo,
   input  ptr_t read_ptr,
   input  ptr_t write_ptr,
   output logic write_ctr_en,
   output logic read_ctr_en,
   output logic ctr_clear,
   output logic fifo_empty,
   output logic fifo_full,
   output logic err
);

   fifo_state_t state;
   fifo_state_t next_state;

   ptr_t write_ptr_nxt;
   ptr_t read_ptr_nxt;
   logic wrap_full;
   logic wrap_empty;
   logic wr_ok;
   logic rd_ok;
   logic refused;

   // Pointer values one step ahead.
   assign write_ptr_nxt = write_ptr + ptr_t'(1);
   assign read_ptr_nxt  = read_ptr + ptr_t'(1);

   assign wrap_full  = (write_ptr_nxt == read_ptr);  // Write would catch up.
   assign wrap_empty = (read_ptr_nxt == write_ptr);  // Pop would catch up.

   // Per-state accept decision and flag decode.
   always_comb begin
      wr_ok      = 1'b0;
      rd_ok      = 1'b0;
      ctr_clear  = 1'b0;
      fifo_empty = 1'b0;
      fifo_full  = 1'b0;
      case (state)
         ST_EMPTY: begin
            fifo_empty = 1'b1;
            wr_ok      = add_fifo;   // No fall-through.
         end
         ST_GOING_FULL: begin
            wr_ok = add_fifo;
            rd_ok = pop_fifo;
         end
         ST_GOING_EMPTY: begin
            wr_ok = add_fifo;
            rd_ok = pop_fifo;
         end
         ST_FULL: begin
            fifo_full = 1'b1;
            rd_ok     = pop_fifo;
         end
         default: begin
            ctr_clear = 1'b1;        // Recover from a bad encoding.
         end
      endcase
   end

   // Direction of the last single operation picks the state.
   always_comb begin
      next_state = state;
      if (ctr_clear) begin
         next_state = ST_EMPTY;
      end else if (wr_ok && !rd_ok) begin
         next_state = wrap_full ? ST_FULL : ST_GOING_FULL;
      end else if (rd_ok && !wr_ok) begin
         next_state = wrap_empty ? ST_EMPTY : ST_GOING_EMPTY;
      end
   end

   assign write_ctr_en = wr_ok;
   assign read_ctr_en  = rd_ok;

   // Any request that was not taken.
   assign refused = (add_fifo & ~wr_ok) | (pop_fifo & ~rd_ok);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_EMPTY;
         err   <= 1'b0;
      end else begin
         state <= next_state;
         err   <= refused;     // One cycle pulse.
      end
   end

endmodule

`default_nettype wire

// ==== fifo4_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_mem import fifo4_pkg::*; #(
   parameter int DATA_W = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              write_ctr_en,
   input  logic              read_ctr_en,
   input  ptr_t              write_ptr,
   input  ptr_t              read_ptr,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_valid
);

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (write_ctr_en) begin
         mem[write_ptr] <= wr_data;
      end
   end

   // Read data holds until the next pop.
   always_ff @(posedge clk) begin
      if (read_ctr_en) begin
         rd_data <= mem[read_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= read_ctr_en;
      end
   end

endmodule

`default_nettype wire

// ==== fifo4_pkg.sv ====
`default_nettype none

package fifo4_pkg;

   localparam int PTR_W = 2;
   localparam int DEPTH = 1 << PTR_W;

   typedef logic [PTR_W-1:0] ptr_t;   // Read or write slot.
   typedef logic [PTR_W:0]   level_t; // Occupancy 0 to 4.

   typedef enum logic [1:0] {
      ST_EMPTY       = 2'b00,
      ST_GOING_FULL  = 2'b01,
      ST_FULL        = 2'b11,
      ST_GOING_EMPTY = 2'b10
   } fifo_state_t;

endpackage

`default_nettype wire

// ==== fifo4_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_props import fifo4_pkg::*; (
   input logic   clk,
   input logic   rst,
   input logic   pop_fifo,
   input logic   fifo_empty,
   input logic   fifo_full,
   input logic   rd_valid,
   input ptr_t   read_ptr,
   input ptr_t   write_ptr,
   input level_t level
);

   // Four writes separate empty from full.
   no_full_after_empty: assert property (@(posedge clk) disable iff (rst)
      fifo_empty |=> !fifo_full)
      else $error("fifo_full rose directly after fifo_empty");

   level_zero_when_empty: assert property (@(posedge clk) disable iff (rst)
      (level == 3'd0) == fifo_empty)
      else $error("level and fifo_empty disagree");

   full_on_wrapped_ptrs: assert property (@(posedge clk) disable iff (rst)
      fifo_full |-> (write_ptr == read_ptr))
      else $error("fifo_full with pointers apart");

   // Read data only follows a pop on a non-empty FIFO.
   valid_after_pop: assert property (@(posedge clk) disable iff (rst)
      rd_valid |-> $past(pop_fifo && !fifo_empty))
      else $error("rd_valid without an accepted pop");

endmodule

bind fifo4_top fifo4_props props_i (
   .clk        (clk),
   .rst        (rst),
   .pop_fifo   (pop_fifo),
   .fifo_empty (fifo_empty),
   .fifo_full  (fifo_full),
   .rd_valid   (rd_valid),
   .read_ptr   (read_ptr),
   .write_ptr  (write_ptr),
   .level      (level)
);

`default_nettype wire

// ==== fifo4_ptr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_ptr_unit import fifo4_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   write_ctr_en,
   input  logic   read_ctr_en,
   input  logic   ctr_clear,
   input  logic   fifo_full,
   output ptr_t   read_ptr,
   output ptr_t   write_ptr,
   output level_t level
);

   ptr_t fill_cnt;

   // Both counters wrap at the depth.
   always_ff @(posedge clk) begin
      if (rst || ctr_clear) begin
         write_ptr <= '0;
         read_ptr  <= '0;
      end else begin
         if (write_ctr_en) begin
            write_ptr <= write_ptr + ptr_t'(1);
         end
         if (read_ctr_en) begin
            read_ptr <= read_ptr + ptr_t'(1);
         end
      end
   end

   assign fill_cnt = write_ptr - read_ptr;   // Modulo depth.

   // Equal pointers mean empty unless the controller says full.
   assign level = fifo_full ? level_t'(DEPTH) : {1'b0, fill_cnt};

endmodule

`default_nettype wire

// ==== fifo4_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_tb import fifo4_pkg::*;;

   localparam int          DATA_W     = 8;
   localparam int          MAX_CYCLES = 2000;
   localparam logic [31:0] SEED       = 32'hebec_9296;

   typedef logic [DATA_W-1:0] data_t;

   logic   clk = 1'b0;
   logic   rst;
   logic   add_fifo;
   logic   pop_fifo;
   data_t  wr_data;
   data_t  rd_data;
   logic   rd_valid;
   logic   fifo_empty;
   logic   fifo_full;
   level_t level;
   logic   err;

   data_t       model_q[$];   // Words the FIFO should hold.
   data_t       last_rd;
   logic        have_rd;
   int unsigned cycles = 0;

   fifo4_top #(
      .DATA_W (DATA_W)
   ) dut_i (
      .clk        (clk),
      .rst        (rst),
      .add_fifo   (add_fifo),
      .pop_fifo   (pop_fifo),
      .wr_data    (wr_data),
      .rd_data    (rd_data),
      .rd_valid   (rd_valid),
      .fifo_empty (fifo_empty),
      .fifo_full  (fifo_full),
      .level      (level),
      .err        (err)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("TB FAILED");
         $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      end
   end

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "Data mismatch");
      end
   endtask

   task automatic check_level(input string name, input level_t exp, input level_t act);
      if (act !== exp) begin
         $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "Level mismatch");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "Flag mismatch");
      end
   endtask

   // One clock of traffic, starting and ending on a falling edge.
   task automatic step(input logic add, input logic pop, input data_t data);
      logic wr_acc;
      logic rd_acc;
      logic exp_err;
      wr_acc  = add && (model_q.size() != DEPTH);
      rd_acc  = pop && (model_q.size() != 0);      // Empty refuses, no fall-through.
      exp_err = (add && !wr_acc) || (pop && !rd_acc);
      add_fifo = add;
      pop_fifo = pop;
      wr_data  = data;
      if (rd_acc) begin
         last_rd = model_q.pop_front();
         have_rd = 1'b1;
      end
      if (wr_acc) begin
         model_q.push_back(data);
      end
      @(posedge clk);
      @(negedge clk);
      add_fifo = 1'b0;
      pop_fifo = 1'b0;
      check_bit("rd_valid", rd_acc, rd_valid);
      if (have_rd) begin
         check_data("rd_data", last_rd, rd_data);   // Holds between pops.
      end
      check_bit("fifo_empty", model_q.size() == 0, fifo_empty);
      check_bit("fifo_full", model_q.size() == DEPTH, fifo_full);
      check_level("level", level_t'(model_q.size()), level);
      check_bit("err", exp_err, err);
   endtask

   task automatic test_reset();
      check_bit("fifo_empty", 1'b1, fifo_empty);
      check_bit("fifo_full", 1'b0, fifo_full);
      check_level("level", 3'd0, level);
      check_bit("err", 1'b0, err);
      check_bit("rd_valid", 1'b0, rd_valid);
   endtask

   task automatic test_fill();
      repeat (4) step(1'b1, 1'b0, data_t'($urandom()));
      check_level("level", 3'd4, level);
      check_bit("fifo_full", 1'b1, fifo_full);
      step(1'b1, 1'b0, data_t'($urandom()));         // Refused write.
      check_bit("err", 1'b1, err);
      check_level("level", 3'd4, level);
      step(1'b0, 1'b0, '0);
      check_bit("err", 1'b0, err);
   endtask

   task automatic test_drain();
      repeat (4) step(1'b0, 1'b1, '0);
      check_bit("fifo_empty", 1'b1, fifo_empty);
      step(1'b0, 1'b1, '0);                           // Refused pop.
      check_bit("err", 1'b1, err);
      check_bit("rd_valid", 1'b0, rd_valid);
      step(1'b0, 1'b0, '0);
   endtask

   task automatic test_simultaneous();
      repeat (2) step(1'b1, 1'b0, data_t'($urandom()));
      step(1'b1, 1'b1, data_t'($urandom()));
      check_level("level", 3'd2, level);
      check_bit("rd_valid", 1'b1, rd_valid);
      repeat (2) step(1'b0, 1'b1, '0);
      // Empty, so only the write lands.
      step(1'b1, 1'b1, data_t'($urandom()));
      check_level("level", 3'd1, level);
      check_bit("rd_valid", 1'b0, rd_valid);
      repeat (3) step(1'b1, 1'b0, data_t'($urandom()));
      // Full, so only the pop lands.
      step(1'b1, 1'b1, data_t'($urandom()));
      check_level("level", 3'd3, level);
      check_bit("rd_valid", 1'b1, rd_valid);
      repeat (3) step(1'b0, 1'b1, '0);
      check_bit("fifo_empty", 1'b1, fifo_empty);
   endtask

   task automatic test_random();
      logic [31:0] bits;
      repeat (200) begin
         bits = $urandom();
         step(bits[0], bits[1], data_t'($urandom()));
      end
   endtask

   initial begin
      void'($urandom(SEED));
      rst      = 1'b1;
      add_fifo = 1'b0;
      pop_fifo = 1'b0;
      wr_data  = '0;
      have_rd  = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      test_reset();
      test_fill();
      test_drain();
      test_simultaneous();
      test_random();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== fifo4_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo4_top import fifo4_pkg::*; #(
   parameter int DATA_W = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              add_fifo,
   input  logic              pop_fifo,
   input  logic [DATA_W-1:0] wr_data,
   output logic [DATA_W-1:0] rd_data,
   output logic              rd_valid,
   output logic              fifo_empty,
   output logic              fifo_full,
   output level_t            level,
   output logic              err
);

   logic write_ctr_en;
   logic read_ctr_en;
   logic ctr_clear;
   ptr_t read_ptr;
   ptr_t write_ptr;

   fifo4_ctrl ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .add_fifo     (add_fifo),
      .pop_fifo     (pop_fifo),
      .read_ptr     (read_ptr),
      .write_ptr    (write_ptr),
      .write_ctr_en (write_ctr_en),
      .read_ctr_en  (read_ctr_en),
      .ctr_clear    (ctr_clear),
      .fifo_empty   (fifo_empty),
      .fifo_full    (fifo_full),
      .err          (err)
   );

   fifo4_ptr_unit ptr_i (
      .clk          (clk),
      .rst          (rst),
      .write_ctr_en (write_ctr_en),
      .read_ctr_en  (read_ctr_en),
      .ctr_clear    (ctr_clear),
      .fifo_full    (fifo_full),
      .read_ptr     (read_ptr),
      .write_ptr    (write_ptr),
      .level        (level)
   );

   fifo4_mem #(
      .DATA_W (DATA_W)
   ) mem_i (
      .clk          (clk),
      .rst          (rst),
      .write_ctr_en (write_ctr_en),
      .read_ctr_en  (read_ctr_en),
      .write_ptr    (write_ptr),
      .read_ptr     (read_ptr),
      .wr_data      (wr_data),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid)
   );

endmodule

`default_nettype wire
